// ==== include/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// data path and address width.
`define MIPS_XLEN 32

// instruction word width.
`define MIPS_ILEN 32

// architectural register count.
`define MIPS_NUM_REGS 32

// first fetch address after reset.
`define MIPS_RESET_PC 32'hbfc0_0000

`endif

// ==== hw/mips_isa_pkg.sv ====
`include "mips_settings.svh"

package mips_isa_pkg;

    typedef logic [`MIPS_XLEN-1:0] word_t;
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0] reg_addr_t;

    // major opcodes of the kept instructions.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // immediate forms share the operation of their register form.
    typedef enum logic [3:0] {
        ALU_ADDU = 4'd0,
        ALU_SUBU = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_NOR  = 4'd5,
        ALU_SLT  = 4'd6,
        ALU_SLTU = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11
    } alu_op_e;

endpackage

// ==== hw/mips_pipe_pkg.sv ====
`include "mips_settings.svh"

package mips_pipe_pkg;

    import mips_isa_pkg::*;

    // fetch to decode.
    typedef struct packed {
        word_t                 pc;
        logic [`MIPS_ILEN-1:0] instr;
    } if_id_t;

    // decode to execute, operands already forwarded.
    typedef struct packed {
        word_t     pc;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        logic [4:0] shamt;
        reg_addr_t dst;
        logic      we;
    } id_ex_t;

    // execute to writeback, also the forwarding source.
    typedef struct packed {
        word_t     pc;
        reg_addr_t dst;
        logic      we;
        word_t     result;
    } ex_wb_t;

endpackage

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  inst_stall_i,
    input  mips_isa_pkg::word_t   inst_sram_rdata_i,
    output mips_isa_pkg::word_t   inst_sram_addr_o,
    output logic                  valid_o,
    output mips_pipe_pkg::if_id_t if_id_o
);

    import mips_isa_pkg::*;

    word_t pc_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= `MIPS_RESET_PC;
        end else if (!inst_stall_i) begin
            pc_q <= pc_q + word_t'(4); // the sram returned this word, move on.
        end
    end

    assign inst_sram_addr_o = pc_q;

    // read data is combinational, so the word belongs to the current pc.
    assign if_id_o.pc    = pc_q;
    assign if_id_o.instr = inst_sram_rdata_i;
    assign valid_o       = !inst_stall_i; // a stalled cycle becomes a bubble.

    pc_aligned_a: assert property (
        @(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00
    ) else $error("fetch pc is not word aligned: %h", pc_q);

endmodule

// ==== hw/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        data_o <= data_i; // only meaningful while valid_o is high.
    end

    payload_known_a: assert property (
        @(posedge clk) disable iff (reset_i)
        valid_o |-> !$isunknown(data_o)
    ) else $error("valid stage payload carries unknown bits");

endmodule

// ==== hw/decode_unit.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module decode_unit (
    input  logic                    valid_i,
    input  mips_pipe_pkg::if_id_t   if_id_i,
    output mips_isa_pkg::reg_addr_t rs_addr_o,
    output mips_isa_pkg::reg_addr_t rt_addr_o,
    input  mips_isa_pkg::word_t     rs_data_i,
    input  mips_isa_pkg::word_t     rt_data_i,
    input  logic                    ex_valid_i,
    input  mips_pipe_pkg::ex_wb_t   ex_fwd_i,
    input  logic                    wb_valid_i,
    input  mips_pipe_pkg::ex_wb_t   wb_fwd_i,
    output logic                    valid_o,
    output mips_pipe_pkg::id_ex_t   id_ex_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rs, rt, rd;
    logic [15:0] imm16;
    word_t     imm;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      zero_ext;
    logic      legal;
    reg_addr_t dst;

    // the younger producer in execute wins over the one in writeback.
    function automatic word_t forward(input reg_addr_t addr, input word_t rf_data,
                                      input logic ex_v, input ex_wb_t ex,
                                      input logic wb_v, input ex_wb_t wb);
        word_t value;
        value = rf_data;
        if (wb_v && wb.we && wb.dst == addr) begin
            value = wb.result;
        end
        if (ex_v && ex.we && ex.dst == addr) begin
            value = ex.result;
        end
        return value;
    endfunction

    assign opcode = opcode_e'(if_id_i.instr[31:26]);
    assign funct  = funct_e'(if_id_i.instr[5:0]);
    assign rs     = if_id_i.instr[25:21];
    assign rt     = if_id_i.instr[20:16];
    assign rd     = if_id_i.instr[15:11];
    assign imm16  = if_id_i.instr[15:0];

    always_comb begin
        alu_op   = ALU_ADDU;
        use_imm  = 1'b1;
        zero_ext = 1'b0;
        legal    = 1'b1;
        dst      = rt;
        case (opcode)
            OP_SPECIAL: begin
                use_imm = 1'b0;
                dst     = rd;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADDU;
                    FN_SUBU: alu_op = ALU_SUBU;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: legal = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADDU;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_ANDI: begin
                alu_op   = ALU_AND;
                zero_ext = 1'b1; // logical immediates are zero extended.
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                zero_ext = 1'b1;
            end
            OP_XORI: begin
                alu_op   = ALU_XOR;
                zero_ext = 1'b1;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                zero_ext = 1'b1;
            end
            default: legal = 1'b0; // retires as a no-op.
        endcase
    end

    assign imm = zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm16}
                          : {{(`MIPS_XLEN-16){imm16[15]}}, imm16};

    assign rs_addr_o = rs;
    assign rt_addr_o = rt;

    assign valid_o        = valid_i;
    assign id_ex_o.pc     = if_id_i.pc;
    assign id_ex_o.alu_op = alu_op;
    assign id_ex_o.op_a   = forward(rs, rs_data_i, ex_valid_i, ex_fwd_i, wb_valid_i, wb_fwd_i);
    assign id_ex_o.op_b   = use_imm ? imm
                          : forward(rt, rt_data_i, ex_valid_i, ex_fwd_i, wb_valid_i, wb_fwd_i);
    assign id_ex_o.shamt  = if_id_i.instr[10:6];
    assign id_ex_o.dst    = dst;
    assign id_ex_o.we     = legal && (dst != '0); // r0 never becomes a retire event.

endmodule

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module execute_unit (
    input  mips_pipe_pkg::id_ex_t id_ex_i,
    output mips_pipe_pkg::ex_wb_t ex_wb_o
);

    import mips_isa_pkg::*;

    word_t a;
    word_t b;
    word_t result;

    assign a = id_ex_i.op_a;
    assign b = id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADDU: result = a + b;
            ALU_SUBU: result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_NOR:  result = ~(a | b);
            ALU_SLT:  result = word_t'($signed(a) < $signed(b));
            ALU_SLTU: result = word_t'(a < b);
            // shifts act on rt and take the amount from the instruction.
            ALU_SLL:  result = b << id_ex_i.shamt;
            ALU_SRL:  result = b >> id_ex_i.shamt;
            ALU_SRA:  result = word_t'($signed(b) >>> id_ex_i.shamt);
            ALU_LUI:  result = b << (`MIPS_XLEN / 2); // immediate into the upper half.
            default:  result = '0;
        endcase
    end

    assign ex_wb_o.pc     = id_ex_i.pc;
    assign ex_wb_o.dst    = id_ex_i.dst;
    assign ex_wb_o.we     = id_ex_i.we;
    assign ex_wb_o.result = result;

endmodule

// ==== hw/regfile.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module regfile (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    we_i,
    input  mips_isa_pkg::reg_addr_t waddr_i,
    input  mips_isa_pkg::word_t     wdata_i,
    input  mips_isa_pkg::reg_addr_t raddr_a_i,
    input  mips_isa_pkg::reg_addr_t raddr_b_i,
    output mips_isa_pkg::word_t     rdata_a_o,
    output mips_isa_pkg::word_t     rdata_b_o
);

    import mips_isa_pkg::*;

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // the same-cycle write is not visible here, decode forwards it instead.
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

    no_r0_write_a: assert property (
        @(posedge clk) disable iff (reset_i)
        we_i |-> (waddr_i != '0)
    ) else $error("register file write addressed to r0");

endmodule

// ==== hw/mips_core_top.sv ====
`timescale 1ns/1ps

module mips_core_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    inst_stall_i,
    input  mips_isa_pkg::word_t     inst_sram_rdata_i,
    output mips_isa_pkg::word_t     inst_sram_addr_o,
    output mips_isa_pkg::word_t     debug_wb_pc_o,
    output logic [3:0]              debug_wb_wen_o,
    output mips_isa_pkg::reg_addr_t debug_wb_num_o,
    output mips_isa_pkg::word_t     debug_wb_data_o
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic      fetch_valid, if_id_valid, id_valid, id_ex_valid, ex_wb_valid;
    if_id_t    fetch_data, if_id_data;
    id_ex_t    id_data, id_ex_data;
    ex_wb_t    ex_data, ex_wb_data;
    reg_addr_t rs_addr, rt_addr;
    word_t     rs_data, rt_data;
    logic      wb_write;

    fetch_unit mips_fetch (
        .clk              (clk),
        .reset_i          (reset_i),
        .inst_stall_i     (inst_stall_i),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .inst_sram_addr_o (inst_sram_addr_o),
        .valid_o          (fetch_valid),
        .if_id_o          (fetch_data)
    );

    stage_reg #(.payload_t(if_id_t)) mips_if_id (
        .clk(clk), .reset_i(reset_i),
        .valid_i(fetch_valid), .data_i(fetch_data),
        .valid_o(if_id_valid), .data_o(if_id_data)
    );

    decode_unit mips_decode (
        .valid_i   (if_id_valid), .if_id_i  (if_id_data),
        .rs_addr_o (rs_addr),     .rt_addr_o(rt_addr),
        .rs_data_i (rs_data),     .rt_data_i(rt_data),
        .ex_valid_i(id_ex_valid), .ex_fwd_i (ex_data),
        .wb_valid_i(ex_wb_valid), .wb_fwd_i (ex_wb_data),
        .valid_o   (id_valid),    .id_ex_o  (id_data)
    );

    stage_reg #(.payload_t(id_ex_t)) mips_id_ex (
        .clk(clk), .reset_i(reset_i),
        .valid_i(id_valid), .data_i(id_data),
        .valid_o(id_ex_valid), .data_o(id_ex_data)
    );

    execute_unit mips_execute (.id_ex_i(id_ex_data), .ex_wb_o(ex_data));

    stage_reg #(.payload_t(ex_wb_t)) mips_ex_wb (
        .clk(clk), .reset_i(reset_i),
        .valid_i(id_ex_valid), .data_i(ex_data),
        .valid_o(ex_wb_valid), .data_o(ex_wb_data)
    );

    assign wb_write = ex_wb_valid && ex_wb_data.we; // bubbles never write.

    regfile mips_regfile (
        .clk      (clk),     .reset_i  (reset_i),
        .we_i     (wb_write), .waddr_i (ex_wb_data.dst), .wdata_i(ex_wb_data.result),
        .raddr_a_i(rs_addr), .raddr_b_i(rt_addr),
        .rdata_a_o(rs_data), .rdata_b_o(rt_data)
    );

    assign debug_wb_pc_o   = ex_wb_data.pc;
    assign debug_wb_wen_o  = {4{wb_write}};
    assign debug_wb_num_o  = ex_wb_data.dst;
    assign debug_wb_data_o = ex_wb_data.result;

endmodule

// ==== tb/wb_checker.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module wb_checker #(
    parameter int PROG_WORDS = 512
) (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    inst_stall_i,
    input  mips_isa_pkg::word_t     inst_sram_addr_i,
    input  mips_isa_pkg::word_t     debug_wb_pc_i,
    input  logic [3:0]              debug_wb_wen_i,
    input  mips_isa_pkg::reg_addr_t debug_wb_num_i,
    input  mips_isa_pkg::word_t     debug_wb_data_i,
    input  logic                    done_i,
    output int                      errors_o,
    output int                      retired_o,
    output int                      writes_o
);

    import mips_isa_pkg::*;

    word_t arch [`MIPS_NUM_REGS];
    word_t prev_addr;
    logic  prev_stall;
    logic  prev_reset = 1'b1;
    logic  finished = 1'b0;
    int    next_idx = 0;
    int    error_count = 0;
    int    retire_count = 0;
    int    write_count = 0;

    assign errors_o  = error_count;
    assign retired_o = retire_count;
    assign writes_o  = write_count;

    initial begin
        for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            arch[i] = '0;
        end
    end

    task automatic mismatch(input string msg);
        error_count++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    // architectural effect of one instruction on the current register state.
    task automatic model_step(input word_t ins, output logic wr, output reg_addr_t rd,
                              output word_t res);
        word_t a;
        word_t b;
        word_t sext;
        word_t zext;
        a    = arch[ins[25:21]];
        b    = arch[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        zext = {16'h0, ins[15:0]};
        wr   = 1'b1;
        rd   = ins[20:16];
        res  = '0;
        case (ins[31:26])
            6'h00: begin
                rd = ins[15:11];
                case (ins[5:0])
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2a: res = {31'h0, $signed(a) < $signed(b)};
                    6'h2b: res = {31'h0, a < b};
                    6'h00: res = b << ins[10:6];
                    6'h02: res = b >> ins[10:6];
                    6'h03: res = $signed(b) >>> ins[10:6];
                    default: wr = 1'b0;
                endcase
            end
            6'h09: res = a + sext;
            6'h0a: res = {31'h0, $signed(a) < $signed(sext)};
            6'h0c: res = a & zext;
            6'h0d: res = a | zext;
            6'h0e: res = a ^ zext;
            6'h0f: res = {ins[15:0], 16'h0};
            default: wr = 1'b0;
        endcase
        if (rd == '0) begin
            wr = 1'b0;
        end
    endtask

    task automatic check_retire();
        logic      wr;
        reg_addr_t rd;
        word_t     res;
        word_t     exp_pc;
        wr = 1'b0;
        while (!wr && next_idx < PROG_WORDS) begin
            model_step(tb_top.prog_mem[next_idx], wr, rd, res);
            next_idx++;
        end
        if (!wr) begin
            mismatch($sformatf("retire of pc %h after the last writing instruction",
                               debug_wb_pc_i));
        end else begin
            exp_pc = `MIPS_RESET_PC + 32'(4 * (next_idx - 1));
            if (debug_wb_pc_i !== exp_pc || debug_wb_num_i !== rd || debug_wb_data_i !== res) begin
                mismatch($sformatf("retire pc %h r%0d = %h, model pc %h r%0d = %h",
                                   debug_wb_pc_i, debug_wb_num_i, debug_wb_data_i,
                                   exp_pc, rd, res));
            end
            arch[rd] = res; // the model keeps its own value, not the DUT's.
            retire_count++;
        end
    endtask

    task automatic check_completion();
        logic      wr;
        reg_addr_t rd;
        word_t     res;
        for (int i = 0; i < PROG_WORDS; i++) begin
            model_step(tb_top.prog_mem[i], wr, rd, res);
            write_count += wr;
        end
        if (retire_count < write_count) begin
            $display("%0d writing instructions never retired", write_count - retire_count);
            error_count++;
        end
    endtask

    // outputs settle after the rising edge, so the falling edge sees them stable.
    always @(negedge clk) begin
        if (reset_i || prev_reset) begin
            if (debug_wb_wen_i !== 4'h0) begin
                mismatch($sformatf("write enable %b during or right after reset",
                                   debug_wb_wen_i));
            end
            if (inst_sram_addr_i !== `MIPS_RESET_PC) begin
                mismatch($sformatf("fetch address %h instead of the reset vector",
                                   inst_sram_addr_i));
            end
        end else begin
            if (inst_sram_addr_i !== (prev_stall ? prev_addr : prev_addr + 32'd4)) begin
                mismatch($sformatf("fetch address %h after %h with stall %b",
                                   inst_sram_addr_i, prev_addr, prev_stall));
            end
            if (debug_wb_wen_i === 4'hf) begin
                check_retire();
            end else if (debug_wb_wen_i !== 4'h0) begin
                mismatch($sformatf("partial write enable %b", debug_wb_wen_i));
            end
        end
        if (done_i && !finished) begin
            finished = 1'b1;
            check_completion();
        end
        prev_reset = reset_i;
        prev_addr  = inst_sram_addr_i;
        prev_stall = inst_stall_i;
    end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps
`include "mips_settings.svh"

module tb_top;

    import mips_isa_pkg::*;

    localparam int PROG_WORDS   = 512;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_PERIOD   = 4;
    localparam logic [65:0] FUNCTS = {6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                      6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
    localparam logic [35:0] IMM_OPS = {6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
    localparam logic [23:0] BAD_OPS = {6'h23, 6'h2b, 6'h04, 6'h1c}; // load, store, branch, mul.

    logic       clk = 1'b0;
    logic       reset_i = 1'b1;
    logic       inst_stall_i = 1'b0;
    word_t      inst_sram_rdata_i;
    word_t      inst_sram_addr_o;
    word_t      debug_wb_pc_o;
    logic [3:0] debug_wb_wen_o;
    reg_addr_t  debug_wb_num_o;
    word_t      debug_wb_data_o;
    word_t      fetch_index;
    word_t      next_pc;
    logic       fetch_done = 1'b0;
    logic       done = 1'b0;
    integer     seed = 32'h5411_cf5b;
    int         errors;
    int         retired;
    int         writes;
    word_t      prog_mem [PROG_WORDS];

    always #(CLK_PERIOD / 2) clk = ~clk;

    mips_core_top i_dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .inst_stall_i     (inst_stall_i),
        .inst_sram_rdata_i(inst_sram_rdata_i),
        .inst_sram_addr_o (inst_sram_addr_o),
        .debug_wb_pc_o    (debug_wb_pc_o),
        .debug_wb_wen_o   (debug_wb_wen_o),
        .debug_wb_num_o   (debug_wb_num_o),
        .debug_wb_data_o  (debug_wb_data_o)
    );

    wb_checker #(.PROG_WORDS(PROG_WORDS)) i_checker (
        .clk(clk), .reset_i(reset_i), .inst_stall_i(inst_stall_i),
        .inst_sram_addr_i(inst_sram_addr_o),
        .debug_wb_pc_i(debug_wb_pc_o), .debug_wb_wen_i(debug_wb_wen_o),
        .debug_wb_num_i(debug_wb_num_o), .debug_wb_data_i(debug_wb_data_o),
        .done_i(done), .errors_o(errors), .retired_o(retired), .writes_o(writes)
    );

    assign fetch_index       = (inst_sram_addr_o - `MIPS_RESET_PC) >> 2;
    assign inst_sram_rdata_i = (fetch_index < PROG_WORDS) ? prog_mem[fetch_index] : '0;

    // most operands come from r0..r3 so that neighbours depend on each other.
    function automatic reg_addr_t pick_reg();
        logic [31:0] r;
        r = $random(seed);
        return (r[2:0] == 3'd0) ? r[8:4] : {3'b000, r[5:4]};
    endfunction

    function automatic word_t random_instr();
        logic [31:0] r;
        int          kind;
        kind = {$random(seed)} % 20;
        r    = $random(seed);
        if (kind < 10) begin
            return {6'h00, pick_reg(), pick_reg(), pick_reg(), r[10:6],
                    FUNCTS[6 * (r[31:16] % 11) +: 6]};
        end else if (kind < 18) begin
            return {IMM_OPS[6 * (r[31:16] % 6) +: 6], pick_reg(), pick_reg(), r[15:0]};
        end else if (kind == 18) begin
            return {BAD_OPS[6 * r[31:30] +: 6], r[25:0]};
        end else begin
            return {6'h00, r[25:6], 6'h18}; // mult has no place without HI/LO.
        end
    endfunction

    // the pc that the DUT will hold after this edge decides the next stall.
    always @(posedge clk) begin
        next_pc = reset_i ? `MIPS_RESET_PC
                : (inst_stall_i ? inst_sram_addr_o : inst_sram_addr_o + 32'd4);
        if (next_pc - `MIPS_RESET_PC >= 4 * PROG_WORDS) begin
            fetch_done   <= 1'b1; // the last word was just accepted.
            inst_stall_i <= 1'b1;
        end else begin
            inst_stall_i <= ($random(seed) & 3) == 0;
        end
    end

    initial begin
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog_mem[i] = random_instr();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        wait (fetch_done);
        repeat (5) @(posedge clk); // three edges to retire, the rest is margin.
        done <= 1'b1;
        repeat (2) @(posedge clk);
        $display("run summary: %0d errors, %0d of %0d writing instructions retired",
                 errors, retired, writes);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // four cycles per instruction covers the worst stall rate with room to spare.
    initial begin
        #((4 * PROG_WORDS + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired at %0t before the program finished", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
hw/mips_isa_pkg.sv
hw/mips_pipe_pkg.sv
hw/fetch_unit.sv
hw/stage_reg.sv
hw/decode_unit.sv
hw/execute_unit.sv
hw/regfile.sv
hw/mips_core_top.sv
tb/wb_checker.sv
tb/tb_top.sv
